//--- verilog/controlUnit_defs.svh
`ifndef CONTROLUNIT_DEFS_SVH
`define CONTROLUNIT_DEFS_SVH

// Instruction fields
`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6

// Sequencer state code
`define STATE_WIDTH 7

// Control word field widths
`define PCSRC_WIDTH 3
`define ALUSRCA_WIDTH 2
`define ALUSRCB_WIDTH 3
`define REGDST_WIDTH 3
`define MEMTOREG_WIDTH 4

// Opcodes
`define OP_RTYPE 6'b000000
`define OP_ADDI 6'b001000
`define OP_ADDIU 6'b001001
`define OP_LUI 6'b001111

// Funct codes of R-type
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_SRL 6'b000010
`define FN_SRA 6'b000011
`define FN_BREAK 6'b001101

// Register file write address select
`define REGDST_RT 3'b010
`define REGDST_RD 3'b001
`define REGDST_SP 3'b101

// Register file write data select
`define MEMTOREG_ALUOUT 4'b1000
`define MEMTOREG_SHIFT 4'b0011
`define MEMTOREG_LUI 4'b1010
`define MEMTOREG_SPINIT 4'b1011

// ALU operand selects
`define ALUSRCA_PC 2'b00
`define ALUSRCA_REGA 2'b10
`define ALUSRCB_REGB 3'b000
`define ALUSRCB_FOUR 3'b001
`define ALUSRCB_IMM 3'b010
`define ALUSRCB_BRANCHOFS 3'b100

`define PCSRC_ALU 3'b001

`endif

//--- verilog/controlUnitPkg.sv
`include "controlUnit_defs.svh"

package controlUnitPkg;

	typedef enum logic [`STATE_WIDTH-1:0] {
		FETCH      = 7'd0,
		WAITFETCH  = 7'd1,
		WAITFETCH2 = 7'd2,
		DECODE     = 7'd3,
		EXEC_ALU   = 7'd4,
		EXEC_IMM   = 7'd5,
		EXEC_SHIFT = 7'd6,
		EXEC_LUI   = 7'd7,
		EXEC_BREAK = 7'd8,
		EXEC_IDLE  = 7'd9,
		WB_RD      = 7'd10,
		WB_RT      = 7'd11,
		WB_SHIFT   = 7'd12,
		WAIT       = {`STATE_WIDTH{1'b1}}
	} stateCode_t;

	typedef enum logic [2:0] {
		RTYPE_ALU,
		IMM_ALU,
		LUI,
		SHIFT,
		BREAK,
		UNSUPPORTED
	} instrClass_t;

	typedef enum logic [2:0] {
		ALU_NONE = 3'd0,
		ALU_ADD  = 3'd1,
		ALU_SUB  = 3'd2,
		ALU_AND  = 3'd3
	} aluOp_t;

	// Codes 1, 3 and 4 match the shifter's control input
	typedef enum logic [2:0] {
		SHIFT_NONE = 3'd0,
		SHIFT_LOAD = 3'd1,
		SHIFT_SRL  = 3'd3,
		SHIFT_SRA  = 3'd4
	} shiftOp_t;

	typedef struct packed {
		instrClass_t instrClass;
		aluOp_t aluOp;
		shiftOp_t shiftOp;
	} decodedInstr_t;

	typedef struct packed {
		logic pcWrite;
		logic [`PCSRC_WIDTH-1:0] pcSource;
		logic regWrite;
		logic irWrite;
		logic writeRegA;
		logic writeRegB;
		logic [`ALUSRCA_WIDTH-1:0] aluSrcA;
		logic [`ALUSRCB_WIDTH-1:0] aluSrcB;
		aluOp_t aluOp;
		logic aluOutControl;
		logic shiftSrc;
		logic shiftAmt;
		shiftOp_t shiftCtrl;
		logic [`REGDST_WIDTH-1:0] regDst;
		logic [`MEMTOREG_WIDTH-1:0] memToReg;
	} controlWord_t;

endpackage

//--- verilog/instrDecoder.sv
`include "controlUnit_defs.svh"

module instrDecoder import controlUnitPkg::*; (
	input logic clock,
	input logic reset,
	input logic [`OPCODE_WIDTH-1:0] opcode,
	input logic [`FUNCT_WIDTH-1:0] funct,
	input logic decodeStrobe,
	output decodedInstr_t decoded
);

	localparam decodedInstr_t NO_INSTR = '{
		instrClass: UNSUPPORTED,
		aluOp: ALU_NONE,
		shiftOp: SHIFT_NONE
	};

	decodedInstr_t tableResult;
	decodedInstr_t held;

	always_comb begin
		tableResult = NO_INSTR;
		case (opcode)
			`OP_RTYPE: begin
				case (funct)
					`FN_ADD: tableResult = '{RTYPE_ALU, ALU_ADD, SHIFT_NONE};
					`FN_SUB: tableResult = '{RTYPE_ALU, ALU_SUB, SHIFT_NONE};
					`FN_AND: tableResult = '{RTYPE_ALU, ALU_AND, SHIFT_NONE};
					`FN_SRL: tableResult = '{SHIFT, ALU_NONE, SHIFT_SRL};
					`FN_SRA: tableResult = '{SHIFT, ALU_NONE, SHIFT_SRA};
					`FN_BREAK: tableResult = '{BREAK, ALU_NONE, SHIFT_NONE};
					default: tableResult = NO_INSTR;
				endcase
			end
			// Unsigned add only differs in overflow handling, same path
			`OP_ADDI, `OP_ADDIU: tableResult = '{IMM_ALU, ALU_ADD, SHIFT_NONE};
			`OP_LUI: tableResult = '{LUI, ALU_NONE, SHIFT_NONE};
			default: tableResult = NO_INSTR;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			held <= NO_INSTR;
		end else if (decodeStrobe) begin
			held <= tableResult;
		end
	end

	// Live table during DECODE so the exit edge sees this instruction
	assign decoded = decodeStrobe ? tableResult : held;

endmodule

//--- verilog/controlSequencer.sv
`include "controlUnit_defs.svh"

module controlSequencer import controlUnitPkg::*; (
	input logic clock,
	input logic reset,
	input instrClass_t instrClass,
	output stateCode_t state,
	output stateCode_t nextState,
	output logic decodeStrobe
);

	// Parked in WAIT so the first edge out of reset lands on FETCH
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= WAIT;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = FETCH;
		case (state)
			FETCH: begin
				nextState = WAITFETCH;
			end
			WAITFETCH: begin
				nextState = WAITFETCH2;
			end
			WAITFETCH2: begin
				nextState = DECODE;
			end
			DECODE: begin
				case (instrClass)
					RTYPE_ALU: nextState = EXEC_ALU;
					IMM_ALU: nextState = EXEC_IMM;
					SHIFT: nextState = EXEC_SHIFT;
					LUI: nextState = EXEC_LUI;
					BREAK: nextState = EXEC_BREAK;
					default: nextState = EXEC_IDLE;
				endcase
			end
			EXEC_ALU: begin
				nextState = WB_RD;
			end
			EXEC_IMM: begin
				nextState = WB_RT;
			end
			EXEC_SHIFT: begin
				nextState = WB_SHIFT;
			end
			// LUI writes in its execute cycle
			EXEC_LUI: begin
				nextState = WAIT;
			end
			EXEC_IDLE: begin
				nextState = WAIT;
			end
			// PC already rewritten, no settling cycle
			EXEC_BREAK: begin
				nextState = FETCH;
			end
			WB_RD, WB_RT, WB_SHIFT: begin
				nextState = WAIT;
			end
			WAIT: begin
				nextState = FETCH;
			end
			default: begin
				nextState = FETCH;
			end
		endcase
	end

	assign decodeStrobe = (state == DECODE);

endmodule

//--- verilog/controlWordGen.sv
`include "controlUnit_defs.svh"

module controlWordGen import controlUnitPkg::*; (
	input logic clock,
	input logic reset,
	input stateCode_t nextState,
	input aluOp_t aluOp,
	input shiftOp_t shiftOp,
	output controlWord_t control
);

	controlWord_t spInitWord;
	controlWord_t nextWord;

	// Loads the stack pointer initial value while held in reset
	always_comb begin
		spInitWord = '0;
		spInitWord.regWrite = 1'b1;
		spInitWord.regDst = `REGDST_SP;
		spInitWord.memToReg = `MEMTOREG_SPINIT;
	end

	always_comb begin
		nextWord = '0;
		case (nextState)
			// PC + 4
			FETCH: begin
				nextWord.aluSrcA = `ALUSRCA_PC;
				nextWord.aluSrcB = `ALUSRCB_FOUR;
			end
			WAITFETCH2: begin
				nextWord.irWrite = 1'b1;
			end
			// Operands into A and B, branch target precomputed
			DECODE: begin
				nextWord.writeRegA = 1'b1;
				nextWord.writeRegB = 1'b1;
				nextWord.aluSrcA = `ALUSRCA_PC;
				nextWord.aluSrcB = `ALUSRCB_BRANCHOFS;
				nextWord.aluOp = ALU_ADD;
				nextWord.aluOutControl = 1'b1;
				nextWord.shiftSrc = 1'b1;
				nextWord.shiftCtrl = SHIFT_LOAD;
			end
			EXEC_ALU: begin
				nextWord.aluSrcA = `ALUSRCA_REGA;
				nextWord.aluSrcB = `ALUSRCB_REGB;
				nextWord.aluOp = aluOp;
				nextWord.aluOutControl = 1'b1;
			end
			EXEC_IMM: begin
				nextWord.aluSrcA = `ALUSRCA_REGA;
				nextWord.aluSrcB = `ALUSRCB_IMM;
				nextWord.aluOp = aluOp;
				nextWord.aluOutControl = 1'b1;
			end
			EXEC_SHIFT: begin
				nextWord.shiftAmt = 1'b1;
				nextWord.shiftCtrl = shiftOp;
			end
			EXEC_LUI: begin
				nextWord.regWrite = 1'b1;
				nextWord.regDst = `REGDST_RT;
				nextWord.memToReg = `MEMTOREG_LUI;
			end
			// Undo the fetch increment
			EXEC_BREAK: begin
				nextWord.pcWrite = 1'b1;
				nextWord.pcSource = `PCSRC_ALU;
				nextWord.aluSrcB = `ALUSRCB_FOUR;
				nextWord.aluOp = ALU_SUB;
			end
			WB_RD: begin
				nextWord.regWrite = 1'b1;
				nextWord.regDst = `REGDST_RD;
				nextWord.memToReg = `MEMTOREG_ALUOUT;
			end
			WB_RT: begin
				nextWord.regWrite = 1'b1;
				nextWord.regDst = `REGDST_RT;
				nextWord.memToReg = `MEMTOREG_ALUOUT;
			end
			WB_SHIFT: begin
				nextWord.regWrite = 1'b1;
				nextWord.regDst = `REGDST_RD;
				nextWord.memToReg = `MEMTOREG_SHIFT;
			end
			default: begin
				nextWord = '0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			control <= spInitWord;
		end else begin
			control <= nextWord;
		end
	end

endmodule

//--- verilog/controlUnit.sv
`include "controlUnit_defs.svh"

module controlUnit import controlUnitPkg::*; (
	input logic clock,
	input logic reset,
	input logic [`OPCODE_WIDTH-1:0] opcode,
	input logic [`FUNCT_WIDTH-1:0] funct,
	output controlWord_t control,
	output stateCode_t stateCode
);

	decodedInstr_t decoded;
	stateCode_t nextState;
	logic decodeStrobe;

	instrDecoder decoder_i (
		.clock(clock),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.decodeStrobe(decodeStrobe),
		.decoded(decoded)
	);

	controlSequencer sequencer_i (
		.clock(clock),
		.reset(reset),
		.instrClass(decoded.instrClass),
		.state(stateCode),
		.nextState(nextState),
		.decodeStrobe(decodeStrobe)
	);

	// Word is registered from nextState, so it lines up with stateCode
	controlWordGen wordGen_i (
		.clock(clock),
		.reset(reset),
		.nextState(nextState),
		.aluOp(decoded.aluOp),
		.shiftOp(decoded.shiftOp),
		.control(control)
	);

endmodule

//--- sim/controlUnit_assertions.sv
`include "controlUnit_defs.svh"

module controlUnitAssertions import controlUnitPkg::*; (
	input logic clock,
	input logic reset,
	input logic [`OPCODE_WIDTH-1:0] opcode,
	input logic [`FUNCT_WIDTH-1:0] funct,
	input controlWord_t control,
	input stateCode_t stateCode
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;
	controlWord_t spWord;
	aluOp_t expectedAluOp;
	stateCode_t expectedExec;

	always_comb begin
		spWord = '0;
		spWord.regWrite = 1'b1;
		spWord.regDst = `REGDST_SP;
		spWord.memToReg = `MEMTOREG_SPINIT;
	end

	// Immediate forms always add
	assign expectedAluOp = (opcode != `OP_RTYPE) ? ALU_ADD :
		(funct == `FN_SUB) ? ALU_SUB : (funct == `FN_AND) ? ALU_AND : ALU_ADD;

	always_comb begin
		case (opcode)
			`OP_ADDI, `OP_ADDIU: expectedExec = EXEC_IMM;
			`OP_LUI: expectedExec = EXEC_LUI;
			`OP_RTYPE: begin
				case (funct)
					`FN_ADD, `FN_SUB, `FN_AND: expectedExec = EXEC_ALU;
					`FN_SRL, `FN_SRA: expectedExec = EXEC_SHIFT;
					`FN_BREAK: expectedExec = EXEC_BREAK;
					default: expectedExec = EXEC_IDLE;
				endcase
			end
			default: expectedExec = EXEC_IDLE;
		endcase
	end

	resetWord: assert property (@(posedge clock) reset |=> control == spWord) else begin
		failCount++;
		$error("Error at %0t: control expected %h, got %h", $time, spWord, $sampled(control));
	end

	firstFetch: assert property (@(posedge clock) $fell(reset) |=> stateCode == FETCH &&
		!control.pcWrite && !control.regWrite && !control.irWrite) else begin
		failCount++;
		$error("First cycle after reset at %0t is not FETCH with writes low", $time);
	end

	fetchOrder: assert property (@(posedge clock) disable iff (reset) stateCode == FETCH |=>
		stateCode == WAITFETCH ##1 stateCode == WAITFETCH2 ##1 stateCode == DECODE) else begin
		failCount++;
		$error("Fetch states out of order before %0t", $time);
	end

	irWriteTiming: assert property (@(posedge clock) disable iff (reset)
		control.irWrite == (stateCode == WAITFETCH2)) else begin
		failCount++;
		$error("Error at %0t: irWrite expected %b, got %b", $time,
			$sampled(stateCode) == WAITFETCH2, $sampled(control.irWrite));
	end

	decodeTarget: assert property (@(posedge clock) disable iff (reset)
		stateCode == DECODE |=> stateCode == expectedExec) else begin
		failCount++;
		$error("Error at %0t: stateCode expected %0d, got %0d", $time,
			$sampled(expectedExec), $sampled(stateCode));
	end

	aluOpValue: assert property (@(posedge clock) disable iff (reset)
		stateCode inside {EXEC_ALU, EXEC_IMM} |-> control.aluOp == expectedAluOp) else begin
		failCount++;
		$error("Error at %0t: aluOp expected %0d, got %0d", $time,
			$sampled(expectedAluOp), $sampled(control.aluOp));
	end

	aluWriteBack: assert property (@(posedge clock) disable iff (reset)
		stateCode inside {EXEC_ALU, EXEC_IMM} |=> control.regWrite &&
		control.memToReg == `MEMTOREG_ALUOUT &&
		control.regDst == ((opcode == `OP_RTYPE) ? `REGDST_RD : `REGDST_RT) &&
		stateCode == ((opcode == `OP_RTYPE) ? WB_RD : WB_RT)) else begin
		failCount++;
		$error("ALU result at %0t not written back to the expected register", $time);
	end

	shiftPath: assert property (@(posedge clock) disable iff (reset) stateCode == EXEC_SHIFT |->
		control.shiftCtrl == ((funct == `FN_SRA) ? SHIFT_SRA : SHIFT_SRL) ##1
		stateCode == WB_SHIFT && control.regWrite && control.regDst == `REGDST_RD &&
		control.memToReg == `MEMTOREG_SHIFT)
		else begin
		failCount++;
		$error("Shift at %0t used the wrong operation or did not write back to rd", $time);
	end

	luiWrite: assert property (@(posedge clock) disable iff (reset) stateCode == EXEC_LUI |->
		control.regWrite && control.regDst == `REGDST_RT &&
		control.memToReg == `MEMTOREG_LUI ##1 stateCode == WAIT) else begin
		failCount++;
		$error("LUI at %0t did not write rt from the LUI source and then wait", $time);
	end

	pcWriteOnlyInBreak: assert property (@(posedge clock) disable iff (reset)
		control.pcWrite == (stateCode == EXEC_BREAK)) else begin
		failCount++;
		$error("Error at %0t: pcWrite expected %b, got %b", $time,
			$sampled(stateCode) == EXEC_BREAK, $sampled(control.pcWrite));
	end

	breakReturn: assert property (@(posedge clock) disable iff (reset)
		stateCode == EXEC_BREAK |=> stateCode == FETCH) else begin
		failCount++;
		$error("BREAK at %0t did not return straight to FETCH", $time);
	end

	idlePass: assert property (@(posedge clock) disable iff (reset)
		stateCode == EXEC_IDLE |-> control == '0 ##1 stateCode == WAIT) else begin
		failCount++;
		$error("Unsupported opcode at %0t raised an enable or skipped WAIT", $time);
	end

endmodule

bind controlUnit controlUnitAssertions assertions_i (.*);

//--- sim/controlUnitTb.sv
`include "controlUnit_defs.svh"

module controlUnitTb import controlUnitPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLOCK_PERIOD = 20;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_INSTR = 60;
	localparam int NUM_KINDS = 10;
	localparam int MAX_INSTR_CYCLES = 7;
	// Every instruction at its longest, plus reset and drain
	localparam int WATCHDOG_NS =
		(NUM_INSTR * MAX_INSTR_CYCLES + RESET_CYCLES + 20) * CLOCK_PERIOD;

	logic clock;
	logic reset;
	logic [`OPCODE_WIDTH-1:0] opcode;
	logic [`FUNCT_WIDTH-1:0] funct;
	controlWord_t control;
	stateCode_t stateCode;
	logic [31:0] randState;

	controlUnit dut_i (
		.clock(clock),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.control(control),
		.stateCode(stateCode)
	);

	function automatic logic [31:0] nextRandom(input logic [31:0] current);
		return current * 32'd1664525 + 32'd1013904223;
	endfunction

	// Kinds 0 to 8 are the kept instructions, 9 is a dropped branch opcode
	task automatic presentInstruction(input int kind, input logic [5:0] filler);
		opcode = `OP_RTYPE;
		funct = filler;
		case (kind)
			0: funct = `FN_ADD;
			1: funct = `FN_SUB;
			2: funct = `FN_AND;
			3: funct = `FN_SRL;
			4: funct = `FN_SRA;
			5: funct = `FN_BREAK;
			6: opcode = `OP_ADDI;
			7: opcode = `OP_ADDIU;
			8: opcode = `OP_LUI;
			default: opcode = 6'b000100;
		endcase
	endtask

	task automatic waitForFetch();
		int cycles = 0;
		while (stateCode != FETCH) begin
			@(negedge clock);
			cycles++;
			if (cycles > MAX_INSTR_CYCLES) begin
				$display("Sequencer did not return to FETCH within %0d cycles", MAX_INSTR_CYCLES);
				$display("** FAIL **");
				$fatal(1, "Instruction did not complete");
			end
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		wait (dut_i.assertions_i.failCount != 0);
		$display("** FAIL **");
		$fatal(1, "Stopped at the first failed check");
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before all instructions ran", WATCHDOG_NS);
		$display("** FAIL **");
		$fatal(1, "Timeout");
	end

	initial begin
		int kind;
		reset = 1'b1;
		opcode = '0;
		funct = '0;
		randState = 32'd61;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < NUM_INSTR; i++) begin
			waitForFetch();
			randState = nextRandom(randState);
			// One of each kind first, random picks after that
			kind = (i < NUM_KINDS) ? i : randState[23:16] % NUM_KINDS;
			presentInstruction(kind, randState[5:0]);
			@(negedge clock);
		end
		waitForFetch();
		repeat (2) @(negedge clock);
		if (dut_i.assertions_i.failCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+verilog
verilog/controlUnitPkg.sv
verilog/instrDecoder.sv
verilog/controlSequencer.sv
verilog/controlWordGen.sv
verilog/controlUnit.sv
sim/controlUnit_assertions.sv
sim/controlUnitTb.sv

//--- Bender.yml
package:
  name: control_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/controlUnitPkg.sv
      - verilog/instrDecoder.sv
      - verilog/controlSequencer.sv
      - verilog/controlWordGen.sv
      - verilog/controlUnit.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/controlUnit_assertions.sv
      - sim/controlUnitTb.sv
